// ==== src/mapper_settings.svh ====
`ifndef MAPPER_SETTINGS_SVH
`define MAPPER_SETTINGS_SVH

// ----------------------------------------------------------------------
// Screen and playfield
// ----------------------------------------------------------------------

`define COORD_WIDTH 10

// Playfield spans columns FIELD_LEFT up to FIELD_RIGHT - 1
`define FIELD_LEFT  80
`define FIELD_RIGHT 560

// ----------------------------------------------------------------------
// Tiles and memories
// ----------------------------------------------------------------------

`define TILE_SIZE     30
`define TILES_PER_ROW 16
`define TILE_PIXELS   900
`define TILE_STATES   16
`define PLAYER_COUNT  2

`define MAP_DEPTH            256
`define BG_PATTERN_DEPTH     (`TILE_STATES * `TILE_PIXELS)
`define PLAYER_PATTERN_DEPTH (`PLAYER_COUNT * `TILE_PIXELS)

// Wide enough for the largest pattern memory
`define MEM_ADDR_WIDTH 14

`endif

// ==== src/mapperPkg.sv ====
`include "mapper_settings.svh"

package mapperPkg;

    typedef logic [`COORD_WIDTH-1:0] coord_t;
    typedef logic [3:0] tileIndex_t;
    typedef logic [3:0] tileState_t;
    typedef logic [3:0] colorIndex_t;

    // 0 to 899 inside one tile
    typedef logic [9:0] pixelOffset_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_t;

    typedef struct packed {
        tileIndex_t col;
        tileIndex_t row;
    } playerPos_t;

    typedef struct packed {
        playerPos_t p1;
        playerPos_t p2;
    } players_t;

    typedef enum logic [1:0] {
        TARGET_MAP,
        TARGET_BACKGROUND,
        TARGET_PLAYER
    } memTarget_t;

    typedef struct packed {
        logic enable;
        memTarget_t target;
        logic [`MEM_ADDR_WIDTH-1:0] address;
        logic [3:0] data;
    } memWrite_t;

    // playerSel is 0 for player 1 and 1 for player 2
    typedef struct packed {
        pixelOffset_t offset;
        logic inField;
        logic playerHit;
        logic playerSel;
    } decoded_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // ------------------------------------------------------------------
    // Palette
    // ------------------------------------------------------------------

    localparam rgb_t backgroundColor = '{8'haa, 8'hea, 8'h66};

    localparam rgb_t paletteColors [16] = '{
        backgroundColor,
        backgroundColor,
        '{8'h3c, 8'hab, 8'hdd},
        '{8'h93, 8'hcf, 8'h81},
        '{8'h98, 8'he7, 8'hd8},
        '{8'h37, 8'he2, 8'hd5},
        '{8'h22, 8'hbb, 8'he6},
        '{8'hfc, 8'hc6, 8'h56},
        '{8'ha8, 8'h7c, 8'h07},
        '{8'hcb, 8'h8c, 8'h1a},
        '{8'he7, 8'h89, 8'h24},
        '{8'hf2, 8'hab, 8'h45},
        '{8'ha0, 8'h61, 8'h1f},
        '{8'h09, 8'h64, 8'hc8},
        '{8'hfb, 8'hfe, 8'hf2},
        '{8'h39, 8'h40, 8'h3a}
    };

endpackage

// ==== src/tileStore.sv ====
module tileStore #(
    parameter type entryT = logic [3:0],
    parameter int depth = 256
) (
    input  logic                     clk,
    input  logic                     writeEnable,
    input  logic [$clog2(depth)-1:0] writeAddress,
    input  entryT                    writeData,
    input  logic [$clog2(depth)-1:0] readAddress,
    output entryT                    readData
);

    entryT mem [depth];

    // Write port
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddress] <= writeData;
        end
    end

    // Read data is valid one edge after the address
    always_ff @(posedge clk) begin
        readData <= mem[readAddress];
    end

endmodule

// ==== src/pixelDecode.sv ====
`include "mapper_settings.svh"

module pixelDecode
    import mapperPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pixel_t     pixel,
    input  players_t   players,
    input  memWrite_t  memWrite,
    output decoded_t   decoded,
    output tileState_t tileState
);

    localparam int mapAddrWidth = $clog2(`MAP_DEPTH);

    typedef logic [mapAddrWidth-1:0] mapAddr_t;

    coord_t     fieldX;
    coord_t     colRem;
    coord_t     rowRem;
    tileIndex_t tileCol;
    tileIndex_t tileRow;
    logic       p1Hit;
    logic       p2Hit;
    decoded_t   decodedNext;
    mapAddr_t   mapReadAddress;
    mapAddr_t   mapWriteAddress;
    logic       mapWriteEnable;

    // ------------------------------------------------------------------
    // Tile math
    // ------------------------------------------------------------------

    // Wraps for x left of the field, masked by inField
    assign fieldX = pixel.x - coord_t'(`FIELD_LEFT);

    assign tileCol = tileIndex_t'(fieldX / `TILE_SIZE);
    assign tileRow = tileIndex_t'(pixel.y / `TILE_SIZE);
    assign colRem  = coord_t'(fieldX % `TILE_SIZE);
    assign rowRem  = coord_t'(pixel.y % `TILE_SIZE);

    // Player 1 checked first so it wins a shared tile
    assign p1Hit = (tileCol == players.p1.col) && (tileRow == players.p1.row);
    assign p2Hit = (tileCol == players.p2.col) && (tileRow == players.p2.row);

    always_comb begin
        decodedNext.offset    = pixelOffset_t'(rowRem * `TILE_SIZE + colRem);
        decodedNext.inField   = (pixel.x >= coord_t'(`FIELD_LEFT)) &&
                                (pixel.x < coord_t'(`FIELD_RIGHT));
        decodedNext.playerHit = p1Hit || p2Hit;
        decodedNext.playerSel = !p1Hit && p2Hit;
    end

    // ------------------------------------------------------------------
    // Tile map
    // ------------------------------------------------------------------

    assign mapReadAddress  = mapAddr_t'(tileRow * `TILES_PER_ROW + tileCol);
    assign mapWriteEnable  = memWrite.enable && (memWrite.target == TARGET_MAP);
    assign mapWriteAddress = mapAddr_t'(memWrite.address);

    tileStore #(
        .entryT(tileState_t),
        .depth (`MAP_DEPTH)
    ) tileMap (
        .clk         (clk),
        .writeEnable (mapWriteEnable),
        .writeAddress(mapWriteAddress),
        .writeData   (memWrite.data),
        .readAddress (mapReadAddress),
        .readData    (tileState)
    );

    // Lines up with the map read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decoded <= '0;
        end else begin
            decoded <= decodedNext;
        end
    end

endmodule

// ==== src/tileFetch.sv ====
`include "mapper_settings.svh"

module tileFetch
    import mapperPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  decoded_t    decoded,
    input  tileState_t  tileState,
    input  memWrite_t   memWrite,
    output colorIndex_t colorIndex,
    output logic        inField
);

    localparam int bgAddrWidth     = $clog2(`BG_PATTERN_DEPTH);
    localparam int playerAddrWidth = $clog2(`PLAYER_PATTERN_DEPTH);

    typedef logic [bgAddrWidth-1:0]     bgAddr_t;
    typedef logic [playerAddrWidth-1:0] playerAddr_t;

    bgAddr_t     bgReadAddress;
    playerAddr_t playerReadAddress;
    logic        bgWriteEnable;
    logic        playerWriteEnable;
    colorIndex_t bgIndex;
    colorIndex_t playerIndex;
    logic        inFieldQ;
    logic        playerHitQ;

    // ------------------------------------------------------------------
    // Pattern memories
    // ------------------------------------------------------------------

    assign bgReadAddress     = bgAddr_t'(tileState * `TILE_PIXELS + decoded.offset);
    assign playerReadAddress =
        playerAddr_t'(decoded.playerSel * `TILE_PIXELS + decoded.offset);

    assign bgWriteEnable     = memWrite.enable && (memWrite.target == TARGET_BACKGROUND);
    assign playerWriteEnable = memWrite.enable && (memWrite.target == TARGET_PLAYER);

    tileStore #(
        .entryT(colorIndex_t),
        .depth (`BG_PATTERN_DEPTH)
    ) backgroundPattern (
        .clk         (clk),
        .writeEnable (bgWriteEnable),
        .writeAddress(bgAddr_t'(memWrite.address)),
        .writeData   (memWrite.data),
        .readAddress (bgReadAddress),
        .readData    (bgIndex)
    );

    tileStore #(
        .entryT(colorIndex_t),
        .depth (`PLAYER_PATTERN_DEPTH)
    ) playerPattern (
        .clk         (clk),
        .writeEnable (playerWriteEnable),
        .writeAddress(playerAddr_t'(memWrite.address)),
        .writeData   (memWrite.data),
        .readAddress (playerReadAddress),
        .readData    (playerIndex)
    );

    // Flags follow the pattern reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inFieldQ   <= 1'b0;
            playerHitQ <= 1'b0;
        end else begin
            inFieldQ   <= decoded.inField;
            playerHitQ <= decoded.playerHit;
        end
    end

    // Sprite overlays the tile pattern
    assign colorIndex = playerHitQ ? playerIndex : bgIndex;
    assign inField    = inFieldQ;

endmodule

// ==== src/paletteMapper.sv ====
module paletteMapper
    import mapperPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  colorIndex_t colorIndex,
    input  logic        inField,
    output rgb_t        rgb
);

    rgb_t rgbNext;

    // ------------------------------------------------------------------
    // Palette lookup
    // ------------------------------------------------------------------

    always_comb begin
        if (inField) begin
            rgbNext = paletteColors[colorIndex];
        end else begin
            // Border left and right of the playfield
            rgbNext = backgroundColor;
        end
    end

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb <= backgroundColor;
        end else begin
            rgb <= rgbNext;
        end
    end

endmodule

// ==== src/colorMapper.sv ====
module colorMapper
    import mapperPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  pixel_t    pixel,
    input  players_t  players,
    input  memWrite_t memWrite,
    output rgb_t      rgb
);

    decoded_t    decoded;
    tileState_t  tileState;
    colorIndex_t colorIndex;
    logic        inField;

    // Decode: tile math and tile map read
    pixelDecode decodeStage (
        .clk      (clk),
        .rst      (rst),
        .pixel    (pixel),
        .players  (players),
        .memWrite (memWrite),
        .decoded  (decoded),
        .tileState(tileState)
    );

    // Execute: pattern fetch and overlay select
    tileFetch fetchStage (
        .clk       (clk),
        .rst       (rst),
        .decoded   (decoded),
        .tileState (tileState),
        .memWrite  (memWrite),
        .colorIndex(colorIndex),
        .inField   (inField)
    );

    // Result: palette and RGB register
    paletteMapper resultStage (
        .clk       (clk),
        .rst       (rst),
        .colorIndex(colorIndex),
        .inField   (inField),
        .rgb       (rgb)
    );

endmodule

// ==== testbench/colorMapper_checker.sv ====
`include "mapper_settings.svh"

module colorMapper_checker
    import mapperPkg::*;
(
    input logic   clk,
    input logic   rst,
    input pixel_t pixel,
    input rgb_t   rgb
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    // ------------------------------------------------------------------
    // Output properties
    // ------------------------------------------------------------------

    property rgbKnown;
        @(posedge clk) disable iff (rst) !$isunknown(rgb);
    endproperty

    property backgroundAfterReset;
        @(posedge clk) $fell(rst) |-> (rgb == backgroundColor);
    endproperty

    // Decode, fetch and palette stages
    property borderIsBackground;
        @(posedge clk) disable iff (rst)
            (pixel.x < coord_t'(`FIELD_LEFT)) |-> ##3 (rgb == backgroundColor);
    endproperty

    rgbKnownCheck: assert property (rgbKnown)
        else begin
            $error("rgb has unknown bits");
            failCount++;
        end
    resetColorCheck: assert property (backgroundAfterReset)
        else begin
            $error("rgb is not the background colour after reset");
            failCount++;
        end
    borderCheck: assert property (borderIsBackground)
        else begin
            $error("left border pixel did not give the background colour");
            failCount++;
        end

endmodule

bind colorMapper colorMapper_checker mapperChecks (
    .clk  (clk),
    .rst  (rst),
    .pixel(pixel),
    .rgb  (rgb)
);

// ==== testbench/colorMapperTb.sv ====
`include "mapper_settings.svh"

module colorMapperTb
    import mapperPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int loadWrites = `MAP_DEPTH + `BG_PATTERN_DEPTH + `PLAYER_PATTERN_DEPTH;
    localparam int sweepRows  = 200;

    typedef struct packed {
        int       testId;
        pixel_t   pixel;
        players_t players;
        rgb_t     expected;
    } tableRow_t;

    logic      clk;
    logic      rst;
    pixel_t    pixel;
    players_t  players;
    memWrite_t memWrite;
    rgb_t      rgb;

    tileState_t  mapMirror [`MAP_DEPTH];
    colorIndex_t bgMirror [`BG_PATTERN_DEPTH];
    colorIndex_t playerMirror [`PLAYER_PATTERN_DEPTH];
    tableRow_t   stimTable [$];

    int    seed = 32'he5249014;
    int    errorCount = 0;
    int    checkCount = 0;
    int    cycleCount = 0;
    int    timeoutLimit = loadWrites + 64;
    int    testErrors [7] = '{default: 0};
    string testNames [7] = '{"", "reset colour", "border", "plain tiles", "player tiles",
                             "back-to-back", "random sweep"};

    colorMapper DUT (
        .clk     (clk),
        .rst     (rst),
        .pixel   (pixel),
        .players (players),
        .memWrite(memWrite),
        .rgb     (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: no result after %0d cycles", timeoutLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    function automatic rgb_t expectedRgb(input pixel_t p, input players_t pl);
        int          x;
        int          y;
        int          col;
        int          row;
        int          offset;
        colorIndex_t idx;
        x = int'(p.x);
        y = int'(p.y);
        if (x < `FIELD_LEFT || x >= `FIELD_RIGHT) begin
            return backgroundColor;
        end
        col    = (x - `FIELD_LEFT) / `TILE_SIZE;
        row    = y / `TILE_SIZE;
        offset = (y % `TILE_SIZE) * `TILE_SIZE + (x - `FIELD_LEFT) % `TILE_SIZE;
        if (col == int'(pl.p1.col) && row == int'(pl.p1.row)) begin
            idx = playerMirror[offset];
        end else if (col == int'(pl.p2.col) && row == int'(pl.p2.row)) begin
            idx = playerMirror[`TILE_PIXELS + offset];
        end else begin
            idx = bgMirror[int'(mapMirror[row * `TILES_PER_ROW + col]) * `TILE_PIXELS + offset];
        end
        return paletteColors[idx];
    endfunction

    // ------------------------------------------------------------------
    // Stimulus table and memory loading
    // ------------------------------------------------------------------

    function automatic void addRow(input int testId, input int x, input int y, input int p1Col,
                                   input int p1Row, input int p2Col, input int p2Row);
        tableRow_t row;
        row             = '0;
        row.testId      = testId;
        row.pixel.x     = coord_t'(x);
        row.pixel.y     = coord_t'(y);
        row.players.p1  = '{tileIndex_t'(p1Col), tileIndex_t'(p1Row)};
        row.players.p2  = '{tileIndex_t'(p2Col), tileIndex_t'(p2Row)};
        stimTable.push_back(row);
    endfunction

    task automatic buildTable();
        int i;
        int x;
        int y;
        int p1Col;
        int p1Row;
        int p2Col;
        int p2Row;
        // Players parked on the edge tiles
        addRow(2, 0, 0, 0, 0, 15, 15);
        addRow(2, 79, 100, 0, 3, 15, 3);
        addRow(2, 560, 200, 15, 6, 0, 6);
        addRow(2, 639, 479, 15, 15, 0, 15);
        addRow(2, 40, 300, 0, 10, 1, 10);
        // Tile corners at offsets 0 and 899
        addRow(3, 80, 0, 5, 7, 12, 3);
        addRow(3, 109, 29, 5, 7, 12, 3);
        addRow(3, 530, 450, 5, 7, 12, 3);
        addRow(3, 559, 479, 5, 7, 12, 3);
        addRow(3, 300, 200, 5, 7, 12, 3);
        addRow(3, 229, 215, 5, 7, 12, 3);
        addRow(4, 230, 210, 5, 7, 12, 3);
        addRow(4, 259, 239, 5, 7, 12, 3);
        addRow(4, 455, 100, 5, 7, 12, 3);
        // Shared tile with player 1 on top
        addRow(4, 335, 250, 8, 8, 8, 8);
        addRow(4, 320, 269, 8, 8, 8, 8);
        addRow(4, 80, 0, 0, 0, 0, 0);
        for (i = 76; i < 86; i++) begin
            addRow(5, i, 31, 0, 1, 3, 3);
        end
        for (i = 224; i < 236; i++) begin
            addRow(5, i, 215, 5, 7, 4, 7);
        end
        for (i = 0; i < sweepRows; i++) begin
            x     = `FIELD_LEFT + {$random(seed)} % (`FIELD_RIGHT - `FIELD_LEFT);
            y     = {$random(seed)} % 480;
            p1Col = {$random(seed)} % 16;
            p1Row = {$random(seed)} % 16;
            p2Col = {$random(seed)} % 16;
            p2Row = {$random(seed)} % 16;
            addRow(6, x, y, p1Col, p1Row, p2Col, p2Row);
        end
    endtask

    task automatic writeWord(input memTarget_t target, input int address, input logic [3:0] data);
        @(posedge clk);
        #1;
        memWrite.enable  = 1'b1;
        memWrite.target  = target;
        memWrite.address = address[`MEM_ADDR_WIDTH-1:0];
        memWrite.data    = data;
    endtask

    task automatic loadMemories();
        int a;
        for (a = 0; a < `MAP_DEPTH; a++) begin
            mapMirror[a] = tileState_t'($random(seed));
            writeWord(TARGET_MAP, a, mapMirror[a]);
        end
        for (a = 0; a < `BG_PATTERN_DEPTH; a++) begin
            bgMirror[a] = colorIndex_t'($random(seed));
            writeWord(TARGET_BACKGROUND, a, bgMirror[a]);
        end
        for (a = 0; a < `PLAYER_PATTERN_DEPTH; a++) begin
            playerMirror[a] = colorIndex_t'($random(seed));
            writeWord(TARGET_PLAYER, a, playerMirror[a]);
        end
        @(posedge clk);
        #1;
        memWrite = '0;
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    task automatic checkRgb(input tableRow_t row);
        checkCount++;
        assert (rgb == row.expected) else begin
            $display("** Error at %0t: test %0d pixel (%0d,%0d) gave rgb %h, expected %h",
                     $time, row.testId, row.pixel.x, row.pixel.y, rgb, row.expected);
            errorCount++;
            testErrors[row.testId]++;
        end
    endtask

    task automatic reportTest(input int testId, input int rows);
        $display("Test %0d %s: %0d pixels checked, %0d mismatches",
                 testId, testNames[testId], rows, testErrors[testId]);
    endtask

    // Three rows in flight at a time
    task automatic runTest(input int testId);
        tableRow_t pending [$];
        int        rows;
        rows = 0;
        foreach (stimTable[i]) begin
            if (stimTable[i].testId == testId) begin
                @(posedge clk);
                #1;
                if (pending.size() == 3) begin
                    checkRgb(pending.pop_front());
                end
                pixel   = stimTable[i].pixel;
                players = stimTable[i].players;
                pending.push_back(stimTable[i]);
                rows++;
            end
        end
        while (pending.size() > 0) begin
            @(posedge clk);
            #1;
            checkRgb(pending.pop_front());
        end
        reportTest(testId, rows);
    endtask

    initial begin
        tableRow_t resetRow;
        tableRow_t row;
        rst      = 1'b1;
        pixel    = '0;
        players  = '0;
        memWrite = '0;
        buildTable();
        timeoutLimit = loadWrites + stimTable.size() + 64;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        resetRow          = '0;
        resetRow.testId   = 1;
        resetRow.expected = backgroundColor;
        checkRgb(resetRow);
        repeat (2) begin
            @(posedge clk);
            #1;
            checkRgb(resetRow);
        end
        reportTest(1, 3);

        loadMemories();
        foreach (stimTable[i]) begin
            row          = stimTable[i];
            row.expected = expectedRgb(row.pixel, row.players);
            stimTable[i] = row;
        end

        for (int t = 2; t <= 6; t++) begin
            runTest(t);
        end

        if (DUT.mapperChecks.failCount != 0) begin
            $display("Bound checker flagged %0d assertion failures",
                     DUT.mapperChecks.failCount);
            errorCount += DUT.mapperChecks.failCount;
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/mapperPkg.sv
src/tileStore.sv
src/pixelDecode.sv
src/tileFetch.sv
src/paletteMapper.sv
src/colorMapper.sv
testbench/colorMapper_checker.sv
testbench/colorMapperTb.sv

// ==== Makefile ====
# Verilator build and run for the colour mapper testbench

VERILATOR  ?= verilator
TOP        ?= colorMapperTb
DUT_TOP    ?= colorMapper
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) src/mapper_settings.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
